// File: bus_merge.sv
module bus_merge
    import mem_bus_pkg::*;
(
    input  mem_req_t                   master_drive [NUM_MASTERS],
    input  logic     [NUM_MASTERS-1:0] master_busy,
    output mem_req_t                   mem_bus,
    output logic                       bus_busy
);

    mem_req_t merged;

    // Each master zeroes its drive when it does not own the bus.
    // So a plain OR gives the value of the single owner.
    always_comb begin
        merged = '0;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            merged = merged | master_drive[i];
        end
    end

    assign mem_bus = merged;

    // Shared level that holds off every waiting master.
    assign bus_busy = |master_busy;

endmodule

// File: mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int NUM_MASTERS = 2;

    localparam int MEM_DEPTH   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_DEPTH); // Word index taken from address bits 9:2.
    localparam logic [DATA_W-1:0] MEM_PATTERN = 32'hc3a5_5a3c;

    localparam int LAT_W       = 3; // Holds 1 + addr[1:0].

    // One master's drive of the shared bus.
    typedef struct packed {
        logic              enable;
        logic              request;
        logic              rd_wr;   // Always 0 for read.
        logic [ADDR_W-1:0] address;
    } mem_req_t;

    // Memory answer seen by all masters.
    typedef struct packed {
        logic              data_valid;
        logic [DATA_W-1:0] data;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        WAIT_BUS = 2'b01,
        OWN_BUS  = 2'b10
    } master_state_t;

endpackage

// File: read_memory.sv
module read_memory
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t mem_bus,
    output mem_rsp_t mem_rsp
);

    logic [DATA_W-1:0]    mem [MEM_DEPTH];
    logic [MEM_IDX_W-1:0] idx;
    logic [DATA_W-1:0]    echo;
    logic [DATA_W-1:0]    rdata;

    logic             active; // Enable seen on an earlier edge.
    logic [LAT_W-1:0] cnt;
    logic             data_valid;

    assign idx = mem_bus.address[MEM_IDX_W+1:2];

    // Address bits outside the index come back straight from the request.
    assign echo = {mem_bus.address[ADDR_W-1:MEM_IDX_W+2], {MEM_IDX_W{1'b0}},
                   mem_bus.address[1:0]};

    // Contents are the word address XOR the pattern.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= DATA_W'(i << 2) ^ MEM_PATTERN;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            cnt        <= '0;
            data_valid <= 1'b0;
        end else if (!mem_bus.enable) begin
            active     <= 1'b0;
            cnt        <= '0;
            data_valid <= 1'b0;
        end else if (!active) begin
            active <= 1'b1;
            cnt    <= LAT_W'(mem_bus.address[1:0]) + LAT_W'(1); // Latency depends on addr[1:0].
        end else if (cnt != '0) begin
            cnt <= cnt - LAT_W'(1);
            if (cnt == LAT_W'(1)) begin
                data_valid <= 1'b1; // Held until enable drops.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_bus.enable && active && cnt == LAT_W'(1)) begin
            rdata <= mem[idx] ^ echo;
        end
    end

    assign mem_rsp.data_valid = data_valid;
    assign mem_rsp.data       = rdata;

endmodule

// File: read_subsystem.sv
module read_subsystem
    import mem_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic [NUM_MASTERS-1:0] req_valid,
    output logic [NUM_MASTERS-1:0] req_ready,
    input  logic [ADDR_W-1:0]      req_address [NUM_MASTERS],

    output logic [NUM_MASTERS-1:0] dp_valid,
    input  logic [NUM_MASTERS-1:0] dp_ready,
    output logic [DATA_W-1:0]      dp_read_data [NUM_MASTERS]
);

    logic [NUM_MASTERS:0]   grant;        // grant[i] feeds master i.
    logic [NUM_MASTERS-1:0] master_busy;
    logic                   bus_busy;
    mem_req_t               master_drive [NUM_MASTERS];
    mem_req_t               mem_bus;
    mem_rsp_t               mem_rsp;

    assign grant[0] = 1'b1; // Head of the chain always holds the grant.

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
        simple_read_master master_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .req_valid    (req_valid[i]),
            .req_ready    (req_ready[i]),
            .req_address  (req_address[i]),
            .dp_valid     (dp_valid[i]),
            .dp_ready     (dp_ready[i]),
            .dp_read_data (dp_read_data[i]),
            .mem_drive    (master_drive[i]),
            .mem_rsp      (mem_rsp),
            .grant_in     (grant[i]),
            .grant_out    (grant[i+1]),
            .bus_busy_out (master_busy[i]),
            .bus_busy_in  (bus_busy)
        );
    end

    bus_merge bus_merge_i (
        .master_drive (master_drive),
        .master_busy  (master_busy),
        .mem_bus      (mem_bus),
        .bus_busy     (bus_busy)
    );

    read_memory read_memory_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_bus (mem_bus),
        .mem_rsp (mem_rsp)
    );

endmodule

// File: read_subsystem_sva.sv
module read_subsystem_sva
    import mem_bus_pkg::*;
(
    input logic                   clk,
    input logic                   rst_n,
    input logic [NUM_MASTERS-1:0] req_valid,
    input logic [NUM_MASTERS-1:0] req_ready,
    input logic [ADDR_W-1:0]      req_address [NUM_MASTERS],
    input logic [NUM_MASTERS-1:0] dp_valid,
    input logic [NUM_MASTERS-1:0] dp_ready,
    input logic [DATA_W-1:0]      dp_read_data [NUM_MASTERS],
    input mem_req_t               mem_bus,
    input mem_rsp_t               mem_rsp,
    input master_state_t          state0,
    input master_state_t          state1
);

    timeunit 1ns;
    timeprecision 1ns;

    int                     err_cnt = 0;
    logic [NUM_MASTERS-1:0] own;
    logic [NUM_MASTERS-1:0] accept;
    logic [NUM_MASTERS-1:0] pend;      // Accepted, data not yet delivered.
    logic [ADDR_W-1:0]      exp_addr [NUM_MASTERS];
    logic [DATA_W-1:0]      exp_data [NUM_MASTERS];
    logic                   seen_req;
    logic                   both_pend; // Both taken together and master 0 still busy.
    logic [7:0]             en_cycles;
    logic [7:0]             lat_exp;

    assign own     = {state1 == OWN_BUS, state0 == OWN_BUS};
    assign accept  = req_valid & req_ready;
    assign lat_exp = 8'd2 + 8'(mem_bus.address[1:0]);

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            exp_data[i] = exp_addr[i] ^ MEM_PATTERN;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend      <= '0;
            seen_req  <= 1'b0;
            both_pend <= 1'b0;
            en_cycles <= '0;
        end else begin
            pend <= (pend & ~dp_valid) | accept;
            if (|req_valid) begin
                seen_req <= 1'b1;
            end
            if (&accept) begin
                both_pend <= 1'b1;
            end else if (dp_valid[0]) begin
                both_pend <= 1'b0;
            end
            if (!mem_bus.enable) begin
                en_cycles <= '0;
            end else if (en_cycles != 8'hff) begin
                en_cycles <= en_cycles + 8'd1; // Edges seen with enable high.
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (accept[i]) begin
                exp_addr[i] <= req_address[i];
            end
        end
    end

    a_reset_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> req_ready == {NUM_MASTERS{1'b1}})
        else begin
            err_cnt++;
            $error("[FAIL] req_ready got %h expected %h", $sampled(req_ready),
                   {NUM_MASTERS{1'b1}});
        end

    a_reset_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> dp_valid == '0)
        else begin
            err_cnt++;
            $error("[FAIL] dp_valid got %h expected %h", $sampled(dp_valid), 2'h0);
        end

    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(own))
        else begin
            err_cnt++;
            $error("more than one master owns the bus");
        end

    a_enable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_bus.enable == (|own))
        else begin
            err_cnt++;
            $error("[FAIL] mem_bus.enable got %h expected %h", $sampled(mem_bus.enable),
                   $sampled(|own));
        end

    a_priority: assert property (@(posedge clk) disable iff (!rst_n)
        both_pend |-> !dp_valid[1])
        else begin
            err_cnt++;
            $error("master 1 delivered before master 0 after a same-cycle request");
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_rsp.data_valid) |-> en_cycles == lat_exp)
        else begin
            err_cnt++;
            $error("[FAIL] data_valid latency got %h expected %h", $sampled(en_cycles),
                   $sampled(lat_exp));
        end

    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_chk
        a_data: assert property (@(posedge clk) disable iff (!rst_n)
            dp_valid[i] |-> dp_read_data[i] == exp_data[i])
            else begin
                err_cnt++;
                $error("[FAIL] dp_read_data[%0d] got %h expected %h", i,
                       $sampled(dp_read_data[i]), $sampled(exp_data[i]));
            end

        a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
            own[i] && !dp_ready[i] |-> !dp_valid[i])
            else begin
                err_cnt++;
                $error("master %0d raised dp_valid while dp_ready was low", i);
            end

        a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
            own[i] && mem_rsp.data_valid && !dp_ready[i] |=> $stable(dp_read_data[i]))
            else begin
                err_cnt++;
                $error("master %0d read data changed while it was held back", i);
            end

        a_one_valid: assert property (@(posedge clk) disable iff (!rst_n)
            dp_valid[i] |-> pend[i])
            else begin
                err_cnt++;
                $error("master %0d delivered data with no request outstanding", i);
            end

        a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
            pend[i] |-> !req_ready[i])
            else begin
                err_cnt++;
                $error("[FAIL] req_ready[%0d] got %h expected %h", i,
                       $sampled(req_ready[i]), 1'b0);
            end

        a_ready_back: assert property (@(posedge clk) disable iff (!rst_n)
            dp_valid[i] |=> req_ready[i])
            else begin
                err_cnt++;
                $error("[FAIL] req_ready[%0d] got %h expected %h", i,
                       $sampled(req_ready[i]), 1'b1);
            end
    end

endmodule

bind read_subsystem read_subsystem_sva read_subsystem_sva_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req_address  (req_address),
    .dp_valid     (dp_valid),
    .dp_ready     (dp_ready),
    .dp_read_data (dp_read_data),
    .mem_bus      (mem_bus),
    .mem_rsp      (mem_rsp),
    .state0       (g_master[0].master_i.state),
    .state1       (g_master[1].master_i.state)
);

// File: read_subsystem_tb.sv
module read_subsystem_tb
    import mem_bus_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int          CLK_PERIOD     = 100;
    localparam int          RESET_CYCLES   = 4;
    localparam int          NUM_TESTS      = 4;
    localparam int          READS_PER_TEST = 8;
    localparam int          TXN_CYCLES     = NUM_MASTERS * 8 + 8; // Two reads plus margin.
    localparam int          ROUND_LIMIT    = 2 * TXN_CYCLES;
    localparam int          WATCHDOG_NS    =
        (RESET_CYCLES + NUM_TESTS * READS_PER_TEST * TXN_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] SEED           = 32'hd24f_615d;

    logic                   clk;
    logic                   rst_n;
    logic [NUM_MASTERS-1:0] req_valid;
    logic [NUM_MASTERS-1:0] req_ready;
    logic [ADDR_W-1:0]      req_address [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] dp_valid;
    logic [NUM_MASTERS-1:0] dp_ready;
    logic [DATA_W-1:0]      dp_read_data [NUM_MASTERS];

    logic        bp_mode; // Random dp_ready when set.
    logic [31:0] rng;
    int          done_cnt [NUM_MASTERS] = '{default: 0};
    int          issued [NUM_MASTERS] = '{default: 0};
    int          tests_run;
    int          tests_failed;
    int          missing;
    int          err_base;

    read_subsystem read_subsystem_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_address  (req_address),
        .dp_valid     (dp_valid),
        .dp_ready     (dp_ready),
        .dp_read_data (dp_read_data)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int assert_errors();
        return read_subsystem_i.read_subsystem_sva_i.err_cnt;
    endfunction

    function automatic bit all_done();
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            ok = ok && (done_cnt[i] >= issued[i]);
        end
        return ok;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : ready_driver
        logic [31:0] bp_rng;
        bp_rng   = SEED;
        dp_ready = '1;
        forever begin
            @(posedge clk);
            if (bp_mode) begin
                bp_rng = next_random(bp_rng);
                dp_ready <= bp_rng[NUM_MASTERS-1:0]; // Each master held back about half the time.
            end else begin
                dp_ready <= '1;
            end
        end
    end

    // Completed reads, counted mid-cycle.
    always @(negedge clk) begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (rst_n && dp_valid[i]) begin
                done_cnt[i]++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic send_reads(input logic [NUM_MASTERS-1:0] mask);
        logic [NUM_MASTERS-1:0] waiting;
        logic [NUM_MASTERS-1:0] accepted;
        int                     cycles;
        waiting = mask;
        cycles  = 0;
        @(posedge clk);
        for (int i = 0; i < NUM_MASTERS; i++) begin
            if (mask[i]) begin
                rng = next_random(rng);
                req_valid[i]   <= 1'b1;
                req_address[i] <= rng;
                issued[i]++;
            end
        end
        while (waiting != '0 && cycles < ROUND_LIMIT) begin
            @(negedge clk);
            accepted = waiting & req_ready;
            @(posedge clk);
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (accepted[i]) begin
                    req_valid[i] <= 1'b0;
                end
            end
            waiting = waiting & ~accepted;
            cycles++;
        end
        if (waiting != '0) begin
            req_valid <= '0;
            missing   += $countones(waiting);
            $display("request mask %h not accepted within %0d cycles", waiting, ROUND_LIMIT);
        end
    endtask

    task automatic wait_reads();
        int cycles;
        cycles = 0;
        while (!all_done() && cycles < ROUND_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!all_done()) begin
            $display("reads still outstanding after %0d cycles", ROUND_LIMIT);
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (issued[i] > done_cnt[i]) begin
                    missing   += issued[i] - done_cnt[i];
                    issued[i] = done_cnt[i];
                end
            end
        end
    endtask

    task automatic start_test();
        err_base = assert_errors();
        missing  = 0;
    endtask

    task automatic finish_test(input string name, input int reads);
        int errs;
        errs = assert_errors() - err_base;
        tests_run++;
        if (errs == 0 && missing == 0) begin
            $display("test %0d %s: ok, %0d reads", tests_run, name, reads);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d assertion failures and %0d missing reads",
                     tests_run, name, errs, missing);
        end
    endtask

    initial begin : main
        logic [NUM_MASTERS-1:0] mask;
        int                     reads;
        rst_n        = 1'b0;
        req_valid    = '0;
        req_address  = '{default: '0};
        bp_mode      = 1'b0;
        rng          = SEED;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        repeat (4) @(posedge clk);
        finish_test("reset state", 0);

        start_test();
        for (int n = 0; n < READS_PER_TEST; n++) begin
            send_reads(NUM_MASTERS'(1 << (n % NUM_MASTERS)));
            wait_reads();
        end
        finish_test("single reads", READS_PER_TEST);

        start_test();
        for (int n = 0; n < READS_PER_TEST / NUM_MASTERS; n++) begin
            send_reads('1); // Same cycle on both masters.
            wait_reads();
        end
        finish_test("same-cycle requests", READS_PER_TEST);

        start_test();
        bp_mode <= 1'b1;
        reads = 0;
        for (int n = 0; n < READS_PER_TEST / NUM_MASTERS; n++) begin
            rng  = next_random(rng);
            mask = rng[NUM_MASTERS-1:0];
            if (mask == '0) begin
                mask = '1;
            end
            reads += $countones(mask);
            send_reads(mask);
            wait_reads();
        end
        bp_mode <= 1'b0;
        finish_test("back-pressure", reads);

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
                 tests_run, tests_run - tests_failed, tests_failed, assert_errors());
        if (tests_failed == 0 && assert_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module read_subsystem_tb -f src.f \
    && ./obj_dir/Vread_subsystem_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && exit 1 || exit 0

// File: simple_read_master.sv
module simple_read_master
    import mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              req_valid,
    output logic              req_ready,
    input  logic [ADDR_W-1:0] req_address,

    output logic              dp_valid,
    input  logic              dp_ready,
    output logic [DATA_W-1:0] dp_read_data,

    output mem_req_t          mem_drive,
    input  mem_rsp_t          mem_rsp,

    input  logic              grant_in,
    output logic              grant_out,

    output logic              bus_busy_out,
    input  logic              bus_busy_in
);

    master_state_t     state;
    master_state_t     state_nxt;
    logic [ADDR_W-1:0] addr_q;

    logic idle;
    logic own;
    logic accept;
    logic win;
    logic done;

    assign idle   = (state == IDLE);
    assign own    = (state == OWN_BUS);
    assign accept = idle && req_valid;
    assign win    = (state == WAIT_BUS) && grant_in && !bus_busy_in; // Bus is ours next edge.
    assign done   = own && mem_rsp.data_valid && dp_ready;

    // Request port.
    assign req_ready = idle;

    // Grant only travels down the chain when this master has nothing to do.
    assign grant_out = grant_in && idle && !req_valid;

    // Data port.
    assign dp_valid     = done;
    assign dp_read_data = mem_rsp.data;

    // Gated drive replaces the tristate bus.
    assign mem_drive.enable  = own;
    assign mem_drive.request = own || win;
    assign mem_drive.rd_wr   = 1'b0;
    assign mem_drive.address = own ? addr_q : '0;

    assign bus_busy_out = own;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    state_nxt = WAIT_BUS;
                end
            end
            WAIT_BUS: begin
                if (grant_in && !bus_busy_in) begin
                    state_nxt = OWN_BUS;
                end
            end
            OWN_BUS: begin
                if (done) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_address; // Latched for the whole transaction.
        end
    end

endmodule

// File: src.f
mem_bus_pkg.sv
simple_read_master.sv
bus_merge.sv
read_memory.sv
read_subsystem.sv
read_subsystem_sva.sv
read_subsystem_tb.sv
